//--- smc_mac_top.f
design/smc_mac_pkg.sv
design/smc_wb_front.sv
design/smc_mac_buffer.sv
design/smc_ext_seq.sv
design/smc_mac_top.sv
bench/ext_sram_model.sv
bench/tb_smc_mac.sv

//--- Makefile
# Verilator build and run for the static memory controller testbench

VERILATOR ?= verilator
TOP       ?= tb_smc_mac
FLIST     ?= smc_mac_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_smc_mac.sv
// directed tests with WAIT_CYCLES=1; word addresses stay below 64 so reads hit earlier writes
`timescale 1ns/100ps
`default_nettype none

module tb_smc_mac;

  import smc_mac_pkg::*;

  localparam int WAIT_CYCLES    = 1;
  localparam int N_RANDOM       = 40;         // mixed transfers
  localparam int TIMEOUT_CYCLES = 60 * 11 * 3; // transfers x worst latency x margin

  logic              sys_clk5;
  logic              n_sys_reset5;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [3:0]        wb_sel;
  logic [WORD_W-1:0] wb_dat_w;
  logic              wb_ack;
  logic [WORD_W-1:0] wb_dat_r;
  logic              ext_cs;
  logic              ext_we;
  logic [ADDR_W+1:0] ext_addr;
  logic [EXT_W-1:0]  ext_wdata;
  logic [EXT_W-1:0]  ext_rdata;

  logic [EXT_W-1:0]  ref_mem [0:255]; // mirror of low model bytes
  logic [31:0]       rng;
  int                wr_access_cnt; // byte writes expected on the bus
  int                access_cnt;
  // bus monitor
  int                cycle_cnt  = 0;
  int                cs_rises   = 0;
  int                cs_cycles  = 0;
  int                we_cycles  = 0;
  logic              cs_q       = 1'b0;
  logic [ADDR_W+1:0] first_addr = '0; // address of access 0

  smc_mac_top #(
    .WAIT_CYCLES  (WAIT_CYCLES)
  ) u_dut (
    .sys_clk5     (sys_clk5),
    .n_sys_reset5 (n_sys_reset5),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_w     (wb_dat_w),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .ext_cs       (ext_cs),
    .ext_we       (ext_we),
    .ext_addr     (ext_addr),
    .ext_wdata    (ext_wdata),
    .ext_rdata    (ext_rdata)
  );

  ext_sram_model u_sram (
    .sys_clk5     (sys_clk5),
    .ext_cs       (ext_cs),
    .ext_we       (ext_we),
    .ext_addr     (ext_addr),
    .ext_wdata    (ext_wdata),
    .ext_rdata    (ext_rdata)
  );

  initial
  begin
    sys_clk5 = 1'b0;
    forever #2 sys_clk5 = ~sys_clk5; // 4 ns
  end

  // --------------------------------------------------
  // failure and compare tasks
  // --------------------------------------------------
  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                            input logic [WORD_W-1:0] act);
    if (act !== exp)
      stop_with_fail($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W+1:0] exp,
                            input logic [ADDR_W+1:0] act);
    if (act !== exp)
      stop_with_fail($sformatf("ERR %s expected %05h actual %05h", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
      stop_with_fail($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
  endtask

  // monitor and watchdog, sampled before this edge's updates
  always @(posedge sys_clk5)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (ext_cs && !cs_q)
    begin
      cs_rises   <= cs_rises + 1;
      first_addr <= ext_addr;
    end
    if (ext_cs)
      cs_cycles <= cs_cycles + 1; // chip select cycles
    if (ext_we)
      we_cycles <= we_cycles + 1; // write strobe cycles
    cs_q <= ext_cs;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_with_fail("timeout: tests did not finish within the cycle limit");
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [EXT_W-1:0] fill_byte(input logic [ADDR_W+1:0] a);
    return a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]} ^ 8'ha5; // power-up content
  endfunction

  // odd select patterns count as a byte
  function automatic int bytes_for_sel(input logic [3:0] sel);
    if (sel == 4'b1111)
      return 4;
    else if (sel == 4'b0011)
      return 2;
    return 1;
  endfunction

  // msb first at ascending addresses
  task automatic mirror_write(input logic [ADDR_W-1:0] adr, input logic [3:0] sel,
                              input logic [WORD_W-1:0] wdat);
    int base;
    int n;
    base = int'(adr) * 4;
    n    = bytes_for_sel(sel);
    for (int k = 0; k < n; k++)
      ref_mem[base+k] = wdat[(n-1-k)*8 +: 8];
  endtask

  function automatic logic [WORD_W-1:0] expect_read(input logic [ADDR_W-1:0] adr,
                                                     input logic [3:0] sel);
    int                base;
    logic [WORD_W-1:0] w;
    base = int'(adr) * 4;
    case (bytes_for_sel(sel))
      4:       w = {ref_mem[base], ref_mem[base+1], ref_mem[base+2], ref_mem[base+3]};
      2:       w = {2{ref_mem[base], ref_mem[base+1]}}; // both halves
      default: w = {4{ref_mem[base]}};                  // all lanes
    endcase
    return w;
  endfunction

  // --------------------------------------------------
  // wishbone transfer with checks
  // --------------------------------------------------
  task automatic run_xfer(input string name, input logic we, input logic [ADDR_W-1:0] adr,
                          input logic [3:0] sel, input logic [WORD_W-1:0] wdat);
    int                lat;
    int                n;
    logic [WORD_W-1:0] rdat;
    n        = bytes_for_sel(sel);
    lat      = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = wdat;
    do
    begin
      @(posedge sys_clk5);
      #1;
      lat++;
    end
    while (!wb_ack);
    rdat = wb_dat_r; // valid in ack cycle
    check_count({name, " latency"}, n * (WAIT_CYCLES + 1) + 3, lat);
    check_addr({name, " base"}, {adr, 2'b00}, first_addr);
    if (ext_cs)
      stop_with_fail({name, ": ext_cs still high in the ack cycle"});
    if (we)
      mirror_write(adr, sel, wdat);
    else
      check_word(name, expect_read(adr, sel), rdat);
    if (we)
      wr_access_cnt = wr_access_cnt + n; // one strobe per byte
    access_cnt = access_cnt + n;
    @(posedge sys_clk5); // request held through ack cycle
    #1;
    if (wb_ack)
      stop_with_fail({name, ": wb_ack high for more than one cycle"});
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_word();
    logic [ADDR_W-1:0] adr;
    logic [WORD_W-1:0] dat;
    int                b;
    rng = xorshift32(rng);
    adr = ADDR_W'(rng[5:0]);
    rng = xorshift32(rng);
    dat = rng;
    b   = int'(adr) * 4;
    run_xfer("word write", 1'b1, adr, 4'b1111, dat);
    check_word("word layout", dat,
               {u_sram.mem[b], u_sram.mem[b+1], u_sram.mem[b+2], u_sram.mem[b+3]});
    run_xfer("word read", 1'b0, adr, 4'b1111, '0);
  endtask

  task automatic test_half();
    logic [ADDR_W-1:0] adr;
    logic [WORD_W-1:0] dat;
    int                b;
    rng = xorshift32(rng);
    adr = ADDR_W'(rng[5:0]);
    rng = xorshift32(rng);
    dat = rng;
    b   = int'(adr) * 4;
    run_xfer("half write", 1'b1, adr, 4'b0011, dat);
    check_word("half layout", {16'd0, dat[15:0]}, {16'd0, u_sram.mem[b], u_sram.mem[b+1]});
    run_xfer("half read", 1'b0, adr, 4'b0011, '0);
  endtask

  task automatic test_byte();
    logic [ADDR_W-1:0] adr;
    logic [WORD_W-1:0] dat;
    int                b;
    rng = xorshift32(rng);
    adr = ADDR_W'(rng[5:0]);
    rng = xorshift32(rng);
    dat = rng;
    b   = int'(adr) * 4;
    run_xfer("byte write", 1'b1, adr, 4'b0001, dat);
    check_word("byte layout", {24'd0, dat[7:0]}, {24'd0, u_sram.mem[b]});
    run_xfer("byte read", 1'b0, adr, 4'b0001, '0);
    run_xfer("odd sel write", 1'b1, adr, 4'b0110, ~dat); // served as low byte
    run_xfer("odd sel read", 1'b0, adr, 4'b1001, '0);
  endtask

  // back to back, random sizes; chip select counts catch replays
  task automatic test_mixed();
    int         acc0;
    int         wr0;
    int         rise0;
    int         cyc0;
    int         we0;
    logic [3:0] sel;
    logic [31:0] dat;
    acc0  = access_cnt;
    wr0   = wr_access_cnt;
    rise0 = cs_rises;
    cyc0  = cs_cycles;
    we0   = we_cycles;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      rng = xorshift32(rng);
      dat = xorshift32(rng);
      case (rng[9:8])
        2'd0:    sel = 4'b1111;
        2'd1:    sel = 4'b0011;
        2'd2:    sel = 4'b0001;
        default: sel = rng[13:10]; // any pattern
      endcase
      run_xfer("mixed", rng[7], ADDR_W'(rng[5:0]), sel, dat);
      rng = dat;
    end
    check_count("mixed transfers", N_RANDOM, cs_rises - rise0);
    check_count("mixed cs cycles", (access_cnt - acc0) * (WAIT_CYCLES + 1), cs_cycles - cyc0);
    // strobe only in the last cycle of each write access
    check_count("mixed write strobes", wr_access_cnt - wr0, we_cycles - we0);
  endtask

  initial
  begin
    n_sys_reset5  = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_sel        = '0;
    wb_dat_w      = '0;
    rng           = 32'h4417872e;
    wr_access_cnt = 0;
    access_cnt    = 0;
    for (int a = 0; a < 256; a++)
      ref_mem[a] = fill_byte((ADDR_W + 2)'(a));
    repeat (16) @(posedge sys_clk5);
    #1;
    n_sys_reset5 = 1'b1;
    @(posedge sys_clk5);
    #1;
    if (wb_ack || ext_cs || ext_we)
      stop_with_fail("outputs not idle after reset");
    test_word();
    test_half();
    test_byte();
    test_mixed();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/ext_sram_model.sv
// asynchronous read, write on the rising edge with ext_cs and ext_we; power-up fill mixes all address bits
`timescale 1ns/100ps
`default_nettype none

module ext_sram_model (
  input  logic                           sys_clk5,
  input  logic                           ext_cs,
  input  logic                           ext_we,
  input  logic [smc_mac_pkg::ADDR_W+1:0] ext_addr,
  input  logic [smc_mac_pkg::EXT_W-1:0]  ext_wdata,
  output logic [smc_mac_pkg::EXT_W-1:0]  ext_rdata
);

  import smc_mac_pkg::*;

  localparam int DEPTH = 1 << (ADDR_W + 2); // whole external space

  logic [EXT_W-1:0] mem [0:DEPTH-1];

  // fill from every address bit, so aliasing shows up
  initial
  begin
    for (int a = 0; a < DEPTH; a++)
    begin
      mem[a] = a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]} ^ 8'ha5;
    end
  end

  always @(posedge sys_clk5)
  begin
    if (ext_cs && ext_we)
      mem[ext_addr] <= ext_wdata; // strobe only in last access cycle
  end

  assign ext_rdata = ext_cs ? mem[ext_addr] : '0; // quiet when deselected

endmodule

`default_nettype wire

//--- design/smc_mac_top.sv
// one transfer in flight; ack latency is n*(WAIT_CYCLES+1)+3 cycles for n byte accesses
`timescale 1ns/100ps
`default_nettype none

module smc_mac_top #(
  parameter int unsigned WAIT_CYCLES = 1
) (
  input  logic                           sys_clk5,
  input  logic                           n_sys_reset5,
  // wishbone classic slave
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [smc_mac_pkg::ADDR_W-1:0] wb_adr,
  input  logic [3:0]                     wb_sel,
  input  logic [smc_mac_pkg::WORD_W-1:0] wb_dat_w,
  output logic                           wb_ack,
  output logic [smc_mac_pkg::WORD_W-1:0] wb_dat_r,
  // external static memory
  output logic                           ext_cs,
  output logic                           ext_we,
  output logic [smc_mac_pkg::ADDR_W+1:0] ext_addr,
  output logic [smc_mac_pkg::EXT_W-1:0]  ext_wdata,
  input  logic [smc_mac_pkg::EXT_W-1:0]  ext_rdata
);

  import smc_mac_pkg::*;

  logic              launch;   // front -> buffer
  smc_req_t          req_new;  // request as presented
  logic              start;    // buffer -> sequencer
  smc_req_t          req_held; // stored request
  smc_beat_t         beat;     // read byte per access
  access_idx_t       cur_idx;
  logic [EXT_W-1:0]  wr_byte;
  logic              done;     // sequencer -> front
  logic [WORD_W-1:0] rd_word;

  // --------------------------------------------------
  // blocks
  // --------------------------------------------------
  smc_wb_front u_front (
    .sys_clk5     (sys_clk5),
    .n_sys_reset5 (n_sys_reset5),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_w     (wb_dat_w),
    .done         (done),
    .rd_word      (rd_word),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .launch       (launch),
    .req          (req_new)
  );

  smc_mac_buffer u_buffer (
    .sys_clk5     (sys_clk5),
    .n_sys_reset5 (n_sys_reset5),
    .launch       (launch),
    .req_in       (req_new),
    .beat         (beat),
    .cur_idx      (cur_idx),
    .start        (start),
    .req_out      (req_held),
    .wr_byte      (wr_byte),
    .rd_word      (rd_word)
  );

  smc_ext_seq #(
    .WAIT_CYCLES  (WAIT_CYCLES)
  ) u_seq (
    .sys_clk5     (sys_clk5),
    .n_sys_reset5 (n_sys_reset5),
    .start        (start),
    .req          (req_held),
    .ext_rdata    (ext_rdata),
    .wr_byte      (wr_byte),
    .cur_idx      (cur_idx),
    .beat         (beat),
    .done         (done),
    .ext_cs       (ext_cs),
    .ext_we       (ext_we),
    .ext_addr     (ext_addr),
    .ext_wdata    (ext_wdata)
  );

endmodule

`default_nettype wire

//--- design/smc_ext_seq.sv
// each access holds ext_cs for WAIT_CYCLES+1 cycles; start must not arrive while busy
`timescale 1ns/100ps
`default_nettype none

module smc_ext_seq #(
  parameter int unsigned WAIT_CYCLES = 1
) (
  input  logic                           sys_clk5,
  input  logic                           n_sys_reset5,
  input  logic                           start,
  input  smc_mac_pkg::smc_req_t          req,
  input  logic [smc_mac_pkg::EXT_W-1:0]  ext_rdata,
  input  logic [smc_mac_pkg::EXT_W-1:0]  wr_byte,
  output smc_mac_pkg::access_idx_t       cur_idx,
  output smc_mac_pkg::smc_beat_t         beat,
  output logic                           done,
  output logic                           ext_cs,
  output logic                           ext_we,
  output logic [smc_mac_pkg::ADDR_W+1:0] ext_addr,
  output logic [smc_mac_pkg::EXT_W-1:0]  ext_wdata
);

  import smc_mac_pkg::*;

  // wait counter sized for at least one bit
  localparam int WAIT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
  localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(WAIT_CYCLES);

  logic [WAIT_W-1:0] wait_cnt; // cycle within the access
  access_idx_t       cnt;      // accesses left after this one
  access_idx_t       made;     // accesses already finished
  logic              last_cyc; // final cycle of an access

  assign last_cyc = ext_cs & (wait_cnt == WAIT_LAST);

  // --------------------------------------------------
  // access counter and wait timing
  // --------------------------------------------------
  always_ff @(posedge sys_clk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
    begin
      ext_cs   <= 1'b0;
      wait_cnt <= '0;
      cnt      <= '0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0; // pulse only
      if (start)
      begin
        ext_cs   <= 1'b1;                       // first access next cycle
        wait_cnt <= '0;
        cnt      <= accesses_for_size(req.size);
      end
      else if (ext_cs)
      begin
        if (last_cyc)
        begin
          wait_cnt <= '0;
          if (cnt == 2'd0)
          begin
            ext_cs <= 1'b0; // last access over
            done   <= 1'b1;
          end
          else
          begin
            cnt <= cnt - 2'd1; // next access back to back
          end
        end
        else
        begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // external bus
  // --------------------------------------------------
  assign made = accesses_for_size(req.size) - cnt;

  // word address times four, then ascending bytes
  assign ext_addr  = {req.addr, 2'b00} + (ADDR_W + 2)'(made);
  assign ext_we    = last_cyc & req.we;                      // strobe on last cycle
  assign ext_wdata = (ext_cs & req.we) ? wr_byte : '0;       // quiet when idle or reading

  assign cur_idx = cnt; // buffer picks the write byte

  // read byte sampled by the buffer at the end of the access
  always_comb
  begin
    beat.valid = last_cyc & ~req.we;
    beat.idx   = cnt;
    beat.data  = ext_rdata;
  end

endmodule

`default_nettype wire

//--- design/smc_mac_buffer.sv
// holds one request at a time; rd_word is valid from done until the next launch
`timescale 1ns/100ps
`default_nettype none

module smc_mac_buffer (
  input  logic                           sys_clk5,
  input  logic                           n_sys_reset5,
  input  logic                           launch,
  input  smc_mac_pkg::smc_req_t          req_in,
  input  smc_mac_pkg::smc_beat_t         beat,
  input  smc_mac_pkg::access_idx_t       cur_idx,
  output logic                           start,
  output smc_mac_pkg::smc_req_t          req_out,
  output logic [smc_mac_pkg::EXT_W-1:0]  wr_byte,
  output logic [smc_mac_pkg::WORD_W-1:0] rd_word
);

  import smc_mac_pkg::*;

  logic [WORD_W-1:0] rd_store; // partial read assembly
  access_idx_t       rep_sel;  // replication choice from stored size

  // --------------------------------------------------
  // request store and start
  // --------------------------------------------------
  always_ff @(posedge sys_clk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
    begin
      req_out <= '0;
      start   <= 1'b0;
    end
    else
    begin
      if (launch)
        req_out <= req_in; // kept for the whole transfer
      start <= launch;     // one cycle behind launch
    end
  end

  // write byte for the current access
  // idx 3 -> bits 31:24, idx 0 -> bits 7:0
  always_comb
  begin
    wr_byte = req_out.wdata[int'(cur_idx)*EXT_W +: EXT_W];
  end

  // --------------------------------------------------
  // read store
  // --------------------------------------------------
  always_ff @(posedge sys_clk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
    begin
      rd_store <= '0;
    end
    else if (launch)
    begin
      rd_store <= '0; // fresh assembly per transfer
    end
    else if (beat.valid)
    begin
      // msb first, so first beat lands in the highest used lane
      rd_store[int'(beat.idx)*EXT_W +: EXT_W] <= beat.data;
    end
  end

  // --------------------------------------------------
  // lane replication
  // --------------------------------------------------
  assign rep_sel = accesses_for_size(req_out.size);

  always_comb
  begin
    case (rep_sel)
      2'd3:
      begin
        rd_word = rd_store; // full word
      end
      2'd1:
      begin
        rd_word = {2{rd_store[2*EXT_W-1:0]}}; // halfword in both halves
      end
      default:
      begin
        rd_word = {4{rd_store[EXT_W-1:0]}}; // byte in all lanes
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/smc_wb_front.sv
// master must hold its request until wb_ack; non-standard wb_sel is served as a low-lane byte
`timescale 1ns/100ps
`default_nettype none

module smc_wb_front (
  input  logic                           sys_clk5,
  input  logic                           n_sys_reset5,
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [smc_mac_pkg::ADDR_W-1:0] wb_adr,
  input  logic [3:0]                     wb_sel,
  input  logic [smc_mac_pkg::WORD_W-1:0] wb_dat_w,
  input  logic                           done,
  input  logic [smc_mac_pkg::WORD_W-1:0] rd_word,
  output logic                           wb_ack,
  output logic [smc_mac_pkg::WORD_W-1:0] wb_dat_r,
  output logic                           launch,
  output smc_mac_pkg::smc_req_t          req
);

  import smc_mac_pkg::*;

  logic       busy; // transfer in flight
  xfer_size_t size; // decoded from select lines

  // --------------------------------------------------
  // size decode
  // --------------------------------------------------
  always_comb
  begin
    case (wb_sel)
      4'b1111: size = XSIZ_32; // all lanes
      4'b0011: size = XSIZ_16; // low halfword
      default: size = XSIZ_8;  // low lane, odd patterns too
    endcase
  end

  // first cycle of a request only
  assign launch = wb_cyc & wb_stb & ~busy & ~wb_ack; // not in ack cycle

  always_comb
  begin
    req.addr  = wb_adr;
    req.we    = wb_we;
    req.size  = size;
    req.wdata = wb_dat_w; // held by master until ack
  end

  // --------------------------------------------------
  // busy flag and ack
  // --------------------------------------------------
  always_ff @(posedge sys_clk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
    begin
      busy   <= 1'b0;
      wb_ack <= 1'b0;
    end
    else
    begin
      if (launch)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0; // free again in ack cycle, ack blocks relaunch
      wb_ack <= done; // one cycle, cycle after done
    end
  end

  // read store is already stable at ack
  assign wb_dat_r = rd_word;

endmodule

`default_nettype wire

//--- design/smc_mac_pkg.sv
// external bus fixed at 8 bits; sizes other than byte, halfword and word are not encoded
`default_nettype none

package smc_mac_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int WORD_W = 32; // wishbone data
  localparam int EXT_W  = 8;  // static memory data
  localparam int ADDR_W = 16; // wishbone word address, ext bus adds 2 bits

  // transfer size as decoded from wb_sel
  typedef enum logic [1:0] {
    XSIZ_8  = 2'b00,
    XSIZ_16 = 2'b01,
    XSIZ_32 = 2'b10
  } xfer_size_t;

  typedef logic [1:0] access_idx_t; // accesses left after the current one

  // one wishbone request, as launched and as stored
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // word address
    logic              we;     // write flag
    xfer_size_t        size;
    logic [WORD_W-1:0] wdata;  // lanes from bit 0
  } smc_req_t;

  // one read byte returned by the sequencer
  typedef struct packed {
    logic             valid;
    access_idx_t      idx;     // also the lane it lands in
    logic [EXT_W-1:0] data;
  } smc_beat_t;

  // starting access count for a size, so n-1
  function automatic access_idx_t accesses_for_size(xfer_size_t size);
    access_idx_t n;
    case (size)
      XSIZ_32: n = 2'd3; // four accesses
      XSIZ_16: n = 2'd1; // two accesses
      default: n = 2'd0; // single access
    endcase
    return n;
  endfunction

endpackage

`default_nettype wire
